/* compile.f */
verilog/axi_ram_pkg.sv
verilog/ram_port_if.sv
verilog/burst_addr_gen.sv
verilog/resp_fifo.sv
verilog/ram_byte_mem.sv
verilog/axi_write_ctrl.sv
verilog/axi_read_ctrl.sv
verilog/axi_resp_queue.sv
verilog/axi_ram_top.sv
tb/tb_axi_ram.sv

/* tb/tb_axi_ram.sv */
/*
 * testbench for the AXI4 slave memory: shadow memory, burst tasks,
 * R and B monitors, protocol assertions and a watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_ram;

    localparam int ADDR_W     = axi_ram_pkg::ADDR_W;
    localparam int DATA_W     = axi_ram_pkg::DATA_W;
    localparam int ID_W       = axi_ram_pkg::ID_W;
    localparam int MEM_WORDS  = 1024;
    localparam int N_INCR     = 10;
    localparam int N_STRB     = 6;
    localparam int N_WRAP     = 8;
    localparam int N_FIXED    = 6;
    localparam int N_BP       = 16;
    localparam int N_HOLD     = 3;
    localparam int TEST_COUNT = N_INCR + N_STRB + N_WRAP + N_FIXED + N_BP + N_HOLD;
    localparam logic [1:0] FIXED = axi_ram_pkg::BURST_FIXED;
    localparam logic [1:0] INCR  = axi_ram_pkg::BURST_INCR;
    localparam logic [1:0] WRAP  = axi_ram_pkg::BURST_WRAP;
    localparam logic [1:0] OKAY  = 2'b00;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;
    } exp_beat_t;

    logic              S_AXI_ACLK = 1'b0;
    logic              S_AXI_ARESETN;
    logic [ID_W-1:0]   S_AXI_AWID, S_AXI_ARID, S_AXI_BID, S_AXI_RID;
    logic [ADDR_W-1:0] S_AXI_AWADDR, S_AXI_ARADDR;
    logic [7:0]        S_AXI_AWLEN, S_AXI_ARLEN;
    logic [1:0]        S_AXI_AWBURST, S_AXI_ARBURST, S_AXI_BRESP, S_AXI_RRESP;
    logic              S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
    logic [DATA_W-1:0] S_AXI_WDATA, S_AXI_RDATA;
    logic [3:0]        S_AXI_WSTRB;
    logic              S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
    logic              S_AXI_RLAST, S_AXI_RVALID, S_AXI_RREADY;

    logic [DATA_W-1:0] shadow [MEM_WORDS];
    exp_beat_t         r_exp [$];
    logic [ID_W-1:0]   b_exp [$];
    integer            seed = 95;
    logic              bp_on;
    logic              rready_hold;
    logic              bready_hold;

    always #4 S_AXI_ACLK = ~S_AXI_ACLK;

    axi_ram_top dut_i (
        .S_AXI_ACLK (S_AXI_ACLK), .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWID (S_AXI_AWID), .S_AXI_AWADDR (S_AXI_AWADDR), .S_AXI_AWLEN (S_AXI_AWLEN),
        .S_AXI_AWBURST (S_AXI_AWBURST), .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA (S_AXI_WDATA), .S_AXI_WSTRB (S_AXI_WSTRB),
        .S_AXI_WVALID (S_AXI_WVALID), .S_AXI_WREADY (S_AXI_WREADY),
        .S_AXI_BID (S_AXI_BID), .S_AXI_BRESP (S_AXI_BRESP),
        .S_AXI_BVALID (S_AXI_BVALID), .S_AXI_BREADY (S_AXI_BREADY),
        .S_AXI_ARID (S_AXI_ARID), .S_AXI_ARADDR (S_AXI_ARADDR), .S_AXI_ARLEN (S_AXI_ARLEN),
        .S_AXI_ARBURST (S_AXI_ARBURST), .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RID (S_AXI_RID), .S_AXI_RDATA (S_AXI_RDATA), .S_AXI_RRESP (S_AXI_RRESP),
        .S_AXI_RLAST (S_AXI_RLAST), .S_AXI_RVALID (S_AXI_RVALID), .S_AXI_RREADY (S_AXI_RREADY)
    );

    task automatic value_fail(input string sig, input logic [63:0] exp, input logic [63:0] act);
        $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
        $display("Verification failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic protocol_fail(input string what);
        $display("[ERROR] t=%0t %s", $time, what);
        $display("Verification failed");
        $fatal(1, "protocol check");
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // word index of one beat, from the AXI burst rules
    function automatic int unsigned beat_word(input logic [ADDR_W-1:0] addr, input int len,
                                              input logic [1:0] burst, input int beat);
        int unsigned start;
        int unsigned size;
        int unsigned word;
        start = addr / 4;
        size  = len + 1;
        case (burst)
            FIXED:   word = start;
            WRAP:    word = start - (start % size) + (start % size + beat) % size;
            default: word = start + beat; // INCR
        endcase
        return word % MEM_WORDS; // upper bits alias
    endfunction

    // protocol rules
    reset_idle: assert property (@(posedge S_AXI_ACLK)
        !S_AXI_ARESETN |=> !S_AXI_BVALID && !S_AXI_RVALID && !S_AXI_WREADY)
        else protocol_fail("BVALID, RVALID or WREADY high right after reset");
    r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=>
            S_AXI_RVALID && $stable({S_AXI_RID, S_AXI_RDATA, S_AXI_RLAST}))
        else protocol_fail("R beat changed or vanished while RREADY was low");
    b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID && $stable(S_AXI_BID))
        else protocol_fail("B response changed or vanished while BREADY was low");
    aw_open: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_AWVALID && S_AXI_AWREADY |=> S_AXI_WREADY && !S_AXI_AWREADY)
        else protocol_fail("write burst did not open after the AW handshake");
    w_rise: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(S_AXI_WREADY) |-> $past(S_AXI_AWVALID && S_AXI_AWREADY))
        else protocol_fail("WREADY rose without an AW handshake");
    ar_busy: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_ARVALID && S_AXI_ARREADY |=> !S_AXI_ARREADY)
        else protocol_fail("ARREADY stayed high after the AR handshake");

    // handshakes seen at negedge complete on the next posedge
    always @(negedge S_AXI_ACLK) begin
        exp_beat_t exp;
        if (S_AXI_ARESETN && S_AXI_RVALID && S_AXI_RREADY) begin
            assert (r_exp.size() != 0) else protocol_fail("R beat with no read beat expected");
            exp = r_exp.pop_front();
            assert (S_AXI_RID === exp.id) else value_fail("S_AXI_RID", exp.id, S_AXI_RID);
            assert (S_AXI_RDATA === exp.data)
                else value_fail("S_AXI_RDATA", exp.data, S_AXI_RDATA);
            assert (S_AXI_RRESP === OKAY) else value_fail("S_AXI_RRESP", OKAY, S_AXI_RRESP);
            assert (S_AXI_RLAST === exp.last)
                else value_fail("S_AXI_RLAST", exp.last, S_AXI_RLAST);
        end
    end

    always @(negedge S_AXI_ACLK) begin
        logic [ID_W-1:0] id;
        if (S_AXI_ARESETN && S_AXI_BVALID && S_AXI_BREADY) begin
            assert (b_exp.size() != 0) else protocol_fail("B response with no write pending");
            id = b_exp.pop_front();
            assert (S_AXI_BID === id) else value_fail("S_AXI_BID", id, S_AXI_BID);
            assert (S_AXI_BRESP === OKAY) else value_fail("S_AXI_BRESP", OKAY, S_AXI_BRESP);
        end
    end

    // ready back-pressure, about half the cycles low when enabled
    always @(posedge S_AXI_ACLK) begin
        S_AXI_RREADY <= !rready_hold && (!bp_on || next_rand() % 2 == 0);
        S_AXI_BREADY <= !bready_hold && (!bp_on || next_rand() % 2 == 0);
    end

    task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                               input int len, input logic [1:0] burst, input bit rand_strb);
        logic [DATA_W-1:0] data;
        logic [3:0]        strb;
        int unsigned       word;
        @(posedge S_AXI_ACLK);
        S_AXI_AWID    <= id;
        S_AXI_AWADDR  <= addr;
        S_AXI_AWLEN   <= 8'(len);
        S_AXI_AWBURST <= burst;
        S_AXI_AWVALID <= 1'b1;
        b_exp.push_back(id);
        @(negedge S_AXI_ACLK);
        while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
        @(posedge S_AXI_ACLK);
        S_AXI_AWVALID <= 1'b0;
        for (int i = 0; i <= len; i++) begin
            data = next_rand();
            strb = rand_strb ? 4'(next_rand()) : 4'hF;
            S_AXI_WDATA  <= data;
            S_AXI_WSTRB  <= strb;
            S_AXI_WVALID <= 1'b1;
            @(negedge S_AXI_ACLK);
            while (!S_AXI_WREADY) @(negedge S_AXI_ACLK);
            word = beat_word(addr, len, burst, i);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[word][8*b +: 8] = data[8*b +: 8];
            end
            @(posedge S_AXI_ACLK);
        end
        S_AXI_WVALID <= 1'b0;
    endtask

    task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input int len, input logic [1:0] burst, input bit hold);
        exp_beat_t beat;
        for (int i = 0; i <= len; i++) begin
            beat.id   = id;
            beat.data = shadow[beat_word(addr, len, burst, i)];
            beat.last = (i == len);
            r_exp.push_back(beat);
        end
        @(posedge S_AXI_ACLK);
        S_AXI_ARID    <= id;
        S_AXI_ARADDR  <= addr;
        S_AXI_ARLEN   <= 8'(len);
        S_AXI_ARBURST <= burst;
        S_AXI_ARVALID <= 1'b1;
        rready_hold   <= hold; // long stall runs the read credit out
        @(negedge S_AXI_ACLK);
        while (!S_AXI_ARREADY) @(negedge S_AXI_ACLK);
        @(posedge S_AXI_ACLK);
        S_AXI_ARVALID <= 1'b0;
        if (hold) begin
            repeat (12) @(posedge S_AXI_ACLK);
            rready_hold <= 1'b0;
        end
        while (r_exp.size() != 0) @(posedge S_AXI_ACLK);
    endtask

    task automatic incr_test(input bit rand_strb);
        logic [ADDR_W-1:0] addr;
        int                len;
        addr = ADDR_W'(next_rand());
        len  = next_rand() % 8;
        write_burst(ID_W'(next_rand()), addr, len, INCR, 1'b0);
        if (rand_strb) write_burst(ID_W'(next_rand()), addr, len, INCR, 1'b1);
        read_burst(ID_W'(next_rand()), addr, len, INCR, 1'b0);
    endtask

    task automatic wrap_test();
        logic [ADDR_W-1:0] addr;
        int                len;
        addr = ADDR_W'(next_rand());
        len  = (2 << (next_rand() % 4)) - 1; // 2, 4, 8 or 16 beats
        write_burst(ID_W'(next_rand()), addr, len, WRAP, 1'b0);
        read_burst(ID_W'(next_rand()), addr, len, WRAP, 1'b0);
        // block read from its base shows where each beat landed
        read_burst(ID_W'(next_rand()), addr & ~ADDR_W'((len + 1) * 4 - 1), len, INCR, 1'b0);
    endtask

    task automatic fixed_test();
        logic [ADDR_W-1:0] addr;
        addr = ADDR_W'(next_rand());
        write_burst(ID_W'(next_rand()), addr, 0, INCR, 1'b0);
        write_burst(ID_W'(next_rand()), addr, 1 + next_rand() % 7, FIXED, 1'b1);
        read_burst(ID_W'(next_rand()), addr, next_rand() % 8, FIXED, 1'b0);
    endtask

    task automatic hold_test();
        logic [ADDR_W-1:0] addr;
        int                len;
        addr = ADDR_W'(next_rand());
        len  = 7 + next_rand() % 9;
        // B queue fills, the fifth AW has to wait for BREADY
        bready_hold <= 1'b1;
        fork
            begin
                repeat (30) @(posedge S_AXI_ACLK);
                bready_hold <= 1'b0;
            end
        join_none
        repeat (6) write_burst(ID_W'(next_rand()), ADDR_W'(next_rand()), 0, INCR, 1'b0);
        write_burst(ID_W'(next_rand()), addr, len, INCR, 1'b0);
        read_burst(ID_W'(next_rand()), addr, len, INCR, 1'b1);
    endtask

    initial begin
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWID    = '0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWLEN   = '0;
        S_AXI_AWBURST = INCR;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARID    = '0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARLEN   = '0;
        S_AXI_ARBURST = INCR;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        bp_on         = 1'b0;
        rready_hold   = 1'b0;
        bready_hold   = 1'b0;
        repeat (3) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(negedge S_AXI_ACLK);
        assert (S_AXI_BVALID === 1'b0) else value_fail("S_AXI_BVALID", 0, S_AXI_BVALID);
        assert (S_AXI_RVALID === 1'b0) else value_fail("S_AXI_RVALID", 0, S_AXI_RVALID);
        assert (S_AXI_AWREADY === 1'b1) else value_fail("S_AXI_AWREADY", 1, S_AXI_AWREADY);
        assert (S_AXI_ARREADY === 1'b1) else value_fail("S_AXI_ARREADY", 1, S_AXI_ARREADY);
        repeat (3) begin
            assert (S_AXI_WREADY === 1'b0) else value_fail("S_AXI_WREADY", 0, S_AXI_WREADY);
            @(negedge S_AXI_ACLK);
        end
        repeat (N_INCR) incr_test(1'b0);
        repeat (N_STRB) incr_test(1'b1);
        repeat (N_WRAP) wrap_test();
        repeat (N_FIXED) fixed_test();
        @(posedge S_AXI_ACLK);
        bp_on <= 1'b1;
        repeat (N_BP) begin
            case (next_rand() % 4)
                0:       incr_test(1'b0);
                1:       incr_test(1'b1);
                2:       wrap_test();
                default: fixed_test();
            endcase
        end
        repeat (N_HOLD) hold_test();
        while (b_exp.size() != 0) @(posedge S_AXI_ACLK);
        repeat (4) @(posedge S_AXI_ACLK);
        $display("Verification passed");
        $finish;
    end

    initial begin
        #(TEST_COUNT * 200 * 8);
        $display("[ERROR] t=%0t timeout, the tests did not finish in time", $time);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* verilog/axi_ram_pkg.sv */
/*
 * shared widths, burst and response codes, queue beat types
 * and the depth of the B and R response queues
 */
`default_nettype none

package axi_ram_pkg;

    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ID_W       = 4;
    localparam int LEN_W      = 8;
    localparam int MEM_AW     = 10; // 1024 words
    localparam int WORD_LSB   = 2;
    localparam int WADDR_W    = ADDR_W - WORD_LSB; // word part of a byte address
    localparam int FIFO_DEPTH = 4;

    // reserved code 3 steps like INCR
    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2
    } burst_e;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } b_beat_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_beat_t;

endpackage

`default_nettype wire

/* verilog/axi_ram_top.sv */
/*
 * AXI4 slave memory top: plain AXI ports, write and read
 * controllers, byte-writable memory and response queues
 */
`timescale 1ns/1ps
`default_nettype none

module axi_ram_top (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire [axi_ram_pkg::ID_W-1:0]     S_AXI_AWID,
    input  wire [axi_ram_pkg::ADDR_W-1:0]   S_AXI_AWADDR,
    input  wire [axi_ram_pkg::LEN_W-1:0]    S_AXI_AWLEN,
    input  wire [1:0]                       S_AXI_AWBURST,
    input  wire                             S_AXI_AWVALID,
    output logic                            S_AXI_AWREADY,
    input  wire [axi_ram_pkg::DATA_W-1:0]   S_AXI_WDATA,
    input  wire [axi_ram_pkg::STRB_W-1:0]   S_AXI_WSTRB,
    input  wire                             S_AXI_WVALID,
    output logic                            S_AXI_WREADY,
    output logic [axi_ram_pkg::ID_W-1:0]    S_AXI_BID,
    output logic [1:0]                      S_AXI_BRESP,
    output logic                            S_AXI_BVALID,
    input  wire                             S_AXI_BREADY,
    input  wire [axi_ram_pkg::ID_W-1:0]     S_AXI_ARID,
    input  wire [axi_ram_pkg::ADDR_W-1:0]   S_AXI_ARADDR,
    input  wire [axi_ram_pkg::LEN_W-1:0]    S_AXI_ARLEN,
    input  wire [1:0]                       S_AXI_ARBURST,
    input  wire                             S_AXI_ARVALID,
    output logic                            S_AXI_ARREADY,
    output logic [axi_ram_pkg::ID_W-1:0]    S_AXI_RID,
    output logic [axi_ram_pkg::DATA_W-1:0]  S_AXI_RDATA,
    output logic [1:0]                      S_AXI_RRESP,
    output logic                            S_AXI_RLAST,
    output logic                            S_AXI_RVALID,
    input  wire                             S_AXI_RREADY
);

    logic                         b_push;
    logic [axi_ram_pkg::ID_W-1:0] b_id;
    logic                         b_full;
    logic                         r_pop;
    logic                         rd_ret_valid;
    logic [axi_ram_pkg::ID_W-1:0] rd_ret_id;
    logic                         rd_ret_last;

    ram_port_if ram_if (.clk(S_AXI_ACLK));

    axi_write_ctrl write_ctrl_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awid          (S_AXI_AWID),
        .awaddr        (S_AXI_AWADDR),
        .awlen         (S_AXI_AWLEN),
        .awburst       (axi_ram_pkg::burst_e'(S_AXI_AWBURST)),
        .awvalid       (S_AXI_AWVALID),
        .wdata         (S_AXI_WDATA),
        .wstrb         (S_AXI_WSTRB),
        .wvalid        (S_AXI_WVALID),
        .b_full        (b_full),
        .awready       (S_AXI_AWREADY),
        .wready        (S_AXI_WREADY),
        .b_push        (b_push),
        .b_id          (b_id),
        .ram           (ram_if.writer)
    );

    axi_read_ctrl read_ctrl_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .arid          (S_AXI_ARID),
        .araddr        (S_AXI_ARADDR),
        .arlen         (S_AXI_ARLEN),
        .arburst       (axi_ram_pkg::burst_e'(S_AXI_ARBURST)),
        .arvalid       (S_AXI_ARVALID),
        .r_pop         (r_pop),
        .arready       (S_AXI_ARREADY),
        .rd_ret_valid  (rd_ret_valid),
        .rd_ret_id     (rd_ret_id),
        .rd_ret_last   (rd_ret_last),
        .ram           (ram_if.reader)
    );

    ram_byte_mem mem_i (
        .S_AXI_ACLK (S_AXI_ACLK),
        .ram        (ram_if.mem)
    );

    axi_resp_queue resp_queue_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .b_push        (b_push),
        .b_id          (b_id),
        .rd_ret_valid  (rd_ret_valid),
        .rd_ret_id     (rd_ret_id),
        .rd_ret_last   (rd_ret_last),
        .rdata         (ram_if.rdata), // aligned with rd_ret_valid
        .bready        (S_AXI_BREADY),
        .rready        (S_AXI_RREADY),
        .b_full        (b_full),
        .r_pop         (r_pop),
        .bid           (S_AXI_BID),
        .bresp         (S_AXI_BRESP),
        .bvalid        (S_AXI_BVALID),
        .rid           (S_AXI_RID),
        .rdata_out     (S_AXI_RDATA),
        .rresp         (S_AXI_RRESP),
        .rlast         (S_AXI_RLAST),
        .rvalid        (S_AXI_RVALID)
    );

endmodule

`default_nettype wire

/* verilog/axi_read_ctrl.sv */
/*
 * AXI read side: AR acceptance, credit-limited memory read issue
 * and tagging of beats coming back from memory
 */
`timescale 1ns/1ps
`default_nettype none

module axi_read_ctrl (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire [axi_ram_pkg::ID_W-1:0]     arid,
    input  wire [axi_ram_pkg::ADDR_W-1:0]   araddr,
    input  wire [axi_ram_pkg::LEN_W-1:0]    arlen,
    input  wire axi_ram_pkg::burst_e        arburst,
    input  wire                             arvalid,
    input  wire                             r_pop,
    output logic                            arready,
    output logic                            rd_ret_valid,
    output logic [axi_ram_pkg::ID_W-1:0]    rd_ret_id,
    output logic                            rd_ret_last,
    ram_port_if.reader                      ram
);

    logic                                    ar_hs;
    logic                                    issue;
    logic                                    busy;
    logic [axi_ram_pkg::ADDR_W-1:0]          beat_addr;
    logic                                    beat_last;
    logic [axi_ram_pkg::ID_W-1:0]            id_q;
    logic [$clog2(axi_ram_pkg::FIFO_DEPTH):0] outstanding; // issued, not yet popped

    assign arready = !busy;
    assign ar_hs   = arvalid && arready;
    // beats in memory plus beats in the R queue never exceed its depth
    assign issue   = busy && (outstanding < axi_ram_pkg::FIFO_DEPTH);

    burst_addr_gen addr_gen_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (ar_hs),
        .start_addr    (araddr),
        .len           (arlen),
        .burst         (arburst),
        .advance       (issue),
        .addr          (beat_addr),
        .last          (beat_last),
        .active        (busy)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_hs) begin
            id_q <= arid;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            outstanding <= '0;
        end else begin
            case ({issue, r_pop})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding; // both or neither
            endcase
        end
    end

    assign ram.re    = issue;
    assign ram.raddr = beat_addr[axi_ram_pkg::WORD_LSB +: axi_ram_pkg::MEM_AW];

    // tags follow the one-cycle memory read latency
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rd_ret_valid <= 1'b0;
        end else begin
            rd_ret_valid <= issue;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        rd_ret_id   <= id_q;
        rd_ret_last <= beat_last;
    end

endmodule

`default_nettype wire

/* verilog/axi_resp_queue.sv */
/*
 * output side: B and R response queues driving the AXI
 * B and R channels, pops on handshake
 */
`timescale 1ns/1ps
`default_nettype none

module axi_resp_queue (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire                             b_push,
    input  wire [axi_ram_pkg::ID_W-1:0]     b_id,
    input  wire                             rd_ret_valid,
    input  wire [axi_ram_pkg::ID_W-1:0]     rd_ret_id,
    input  wire                             rd_ret_last,
    input  wire [axi_ram_pkg::DATA_W-1:0]   rdata,
    input  wire                             bready,
    input  wire                             rready,
    output logic                            b_full,
    output logic                            r_pop,
    output logic [axi_ram_pkg::ID_W-1:0]    bid,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    output logic [axi_ram_pkg::ID_W-1:0]    rid,
    output logic [axi_ram_pkg::DATA_W-1:0]  rdata_out,
    output logic [1:0]                      rresp,
    output logic                            rlast,
    output logic                            rvalid
);

    axi_ram_pkg::b_beat_t b_in;
    axi_ram_pkg::b_beat_t b_out;
    axi_ram_pkg::r_beat_t r_in;
    axi_ram_pkg::r_beat_t r_out;
    logic                 b_empty;
    logic                 r_empty;
    logic                 b_pop;

    assign b_in = '{id: b_id, resp: axi_ram_pkg::RESP_OKAY};
    assign r_in = '{id: rd_ret_id, data: rdata, resp: axi_ram_pkg::RESP_OKAY,
                    last: rd_ret_last};

    assign b_pop = bvalid && bready;
    assign r_pop = rvalid && rready; // also returns read credit

    resp_fifo #(
        .payload_t (axi_ram_pkg::b_beat_t),
        .DEPTH     (axi_ram_pkg::FIFO_DEPTH)
    ) b_fifo_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push          (b_push),
        .din           (b_in),
        .pop           (b_pop),
        .dout          (b_out),
        .empty         (b_empty),
        .full          (b_full)
    );

    // credit in the read side keeps this queue from overflowing
    resp_fifo #(
        .payload_t (axi_ram_pkg::r_beat_t),
        .DEPTH     (axi_ram_pkg::FIFO_DEPTH)
    ) r_fifo_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push          (rd_ret_valid),
        .din           (r_in),
        .pop           (r_pop),
        .dout          (r_out),
        .empty         (r_empty),
        .full          ()
    );

    assign bvalid    = !b_empty;
    assign bid       = b_out.id;
    assign bresp     = b_out.resp;
    assign rvalid    = !r_empty;
    assign rid       = r_out.id;
    assign rdata_out = r_out.data;
    assign rresp     = r_out.resp;
    assign rlast     = r_out.last;

endmodule

`default_nettype wire

/* verilog/axi_write_ctrl.sv */
/*
 * AXI write side: AW/W acceptance, memory writes under WSTRB
 * and one push into the B queue per burst
 */
`timescale 1ns/1ps
`default_nettype none

module axi_write_ctrl (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire [axi_ram_pkg::ID_W-1:0]     awid,
    input  wire [axi_ram_pkg::ADDR_W-1:0]   awaddr,
    input  wire [axi_ram_pkg::LEN_W-1:0]    awlen,
    input  wire axi_ram_pkg::burst_e        awburst,
    input  wire                             awvalid,
    input  wire [axi_ram_pkg::DATA_W-1:0]   wdata,
    input  wire [axi_ram_pkg::STRB_W-1:0]   wstrb,
    input  wire                             wvalid,
    input  wire                             b_full,
    output logic                            awready,
    output logic                            wready,
    output logic                            b_push,
    output logic [axi_ram_pkg::ID_W-1:0]    b_id,
    ram_port_if.writer                      ram
);

    logic                           aw_hs;
    logic                           w_hs;
    logic [axi_ram_pkg::ADDR_W-1:0] beat_addr;
    logic                           beat_last;
    logic                           busy;
    logic [axi_ram_pkg::ID_W-1:0]   id_q;

    // a free B slot is needed before a new burst is taken
    assign awready = !busy && !b_full;
    assign wready  = busy;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    burst_addr_gen addr_gen_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (aw_hs),
        .start_addr    (awaddr),
        .len           (awlen),
        .burst         (awburst),
        .advance       (w_hs),
        .addr          (beat_addr),
        .last          (beat_last),
        .active        (busy)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            id_q <= awid;
        end
    end

    // beat goes straight to memory in the handshake cycle
    assign ram.we    = w_hs;
    assign ram.waddr = beat_addr[axi_ram_pkg::WORD_LSB +: axi_ram_pkg::MEM_AW];
    assign ram.wdata = wdata;
    assign ram.wstrb = wstrb;

    assign b_push = w_hs && beat_last; // beat count from awlen, WLAST not used
    assign b_id   = id_q;

endmodule

`default_nettype wire

/* verilog/burst_addr_gen.sv */
/*
 * beat address and beat count sequencer for one AXI burst
 * FIXED, INCR and WRAP stepping on word addresses
 */
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire                             start,
    input  wire [axi_ram_pkg::ADDR_W-1:0]   start_addr,
    input  wire [axi_ram_pkg::LEN_W-1:0]    len,
    input  wire axi_ram_pkg::burst_e        burst,
    input  wire                             advance,
    output logic [axi_ram_pkg::ADDR_W-1:0]  addr,
    output logic                            last,
    output logic                            active
);

    logic [axi_ram_pkg::WADDR_W-1:0] word_q;
    logic [axi_ram_pkg::WADDR_W-1:0] word_nxt;
    logic [axi_ram_pkg::WADDR_W-1:0] wrap_mask;
    logic [axi_ram_pkg::LEN_W-1:0]   len_q;
    logic [axi_ram_pkg::LEN_W-1:0]   cnt_q;
    axi_ram_pkg::burst_e             burst_q;

    // wrap block is len+1 words, so len itself is the offset mask
    assign wrap_mask = {{(axi_ram_pkg::WADDR_W - axi_ram_pkg::LEN_W){1'b0}}, len_q};

    always_comb begin
        case (burst_q)
            axi_ram_pkg::BURST_FIXED: word_nxt = word_q;
            axi_ram_pkg::BURST_WRAP:
                word_nxt = (word_q & ~wrap_mask) | ((word_q + 1'b1) & wrap_mask);
            default:                  word_nxt = word_q + 1'b1; // INCR and reserved
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            active <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt_q  <= '0;
        end else if (advance && active) begin
            cnt_q <= cnt_q + 1'b1;
            if (last) begin
                active <= 1'b0; // burst done
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (start) begin
            word_q  <= start_addr[axi_ram_pkg::ADDR_W-1:axi_ram_pkg::WORD_LSB];
            len_q   <= len;
            burst_q <= burst;
        end else if (advance && active) begin
            word_q <= word_nxt;
        end
    end

    assign addr = {word_q, {axi_ram_pkg::WORD_LSB{1'b0}}};
    assign last = active && (cnt_q == len_q);

endmodule

`default_nettype wire

/* verilog/ram_byte_mem.sv */
/*
 * pseudo dual-port word memory, per-byte write enables,
 * registered read with one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module ram_byte_mem (
    input  wire     S_AXI_ACLK,
    ram_port_if.mem ram
);

    localparam int BYTE_W = axi_ram_pkg::DATA_W / axi_ram_pkg::STRB_W;

    logic [axi_ram_pkg::DATA_W-1:0] mem_q [2**axi_ram_pkg::MEM_AW];

    always_ff @(posedge S_AXI_ACLK) begin
        if (ram.we) begin
            for (int i = 0; i < axi_ram_pkg::STRB_W; i++) begin
                if (ram.wstrb[i]) begin
                    mem_q[ram.waddr][i*BYTE_W +: BYTE_W] <= ram.wdata[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // same-word read during a write sees the old contents
    always_ff @(posedge S_AXI_ACLK) begin
        if (ram.re) begin
            ram.rdata <= mem_q[ram.raddr];
        end
    end

endmodule

`default_nettype wire

/* verilog/ram_port_if.sv */
/*
 * memory port bundle: byte-masked write port and registered read port
 */
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if (
    input wire clk
);

    logic                             we;
    logic [axi_ram_pkg::MEM_AW-1:0]   waddr;
    logic [axi_ram_pkg::DATA_W-1:0]   wdata;
    logic [axi_ram_pkg::STRB_W-1:0]   wstrb;
    logic                             re;
    logic [axi_ram_pkg::MEM_AW-1:0]   raddr;
    logic [axi_ram_pkg::DATA_W-1:0]   rdata; // valid the cycle after re, held until next read

    modport writer (output we, waddr, wdata, wstrb);

    modport reader (output re, raddr);

    modport mem (
        input  clk, we, waddr, wdata, wstrb, re, raddr,
        output rdata
    );

endinterface

`default_nettype wire

/* verilog/resp_fifo.sv */
/*
 * small synchronous ring-buffer FIFO for any payload type
 * push and pop in the same cycle are both served
 */
`timescale 1ns/1ps
`default_nettype none

module resp_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4 // power of two
) (
    input  wire      S_AXI_ACLK,
    input  wire      S_AXI_ARESETN,
    input  wire      push,
    input  payload_t din,
    input  wire      pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         buf_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty; // pop on empty is dropped

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (do_push) begin
            buf_q[wr_ptr] <= din;
        end
    end

    assign dout  = buf_q[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == DEPTH);

endmodule

`default_nettype wire
